/* router_pkg.sv */
package router_pkg;

	// ==============================
	// line and bookkeeping types
	// ==============================
	typedef logic [2:0] sym_t;         // one symbol on a link line
	typedef logic       link_id_t;     // which link a packet came from
	typedef logic [3:0] credit_cnt_t;  // credits held by the merge stage
	typedef logic [3:0] fifo_lvl_t;    // packets sitting in a link fifo

	// receiver frame machine
	typedef enum logic {
		RX_IDLE,   // hunting for a start symbol
		RX_FRAME   // counting through a frame
	} rx_state_t;

	// ==============================
	// default sizes
	// ==============================
	localparam int DEF_DATA_SYMS  = 16;  // 48 bit packet
	localparam int DEF_FIFO_DEPTH = 8;   // packets per link
	localparam int DEF_CREDITS    = 4;   // credits after reset

	// line encoding
	localparam sym_t SYM_START = 3'd0;   // frame start
	localparam sym_t SYM_STOP  = 3'd7;   // stop and idle level
	localparam int   OVERSAMPLE = 4;     // clocks per symbol

endpackage

/* router_pkt_fifo.sv */
`timescale 1ns/1ns

module router_pkt_fifo #(
	parameter int WIDTH = router_pkg::DEF_DATA_SYMS * 3,
	parameter int DEPTH = router_pkg::DEF_FIFO_DEPTH
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  wr_i,     // push wdata_i
	input  logic [WIDTH-1:0]      wdata_i,
	input  logic                  rd_i,     // pop head entry
	output logic [WIDTH-1:0]      rdata_o,  // head entry, valid while not empty
	output logic                  empty_o,
	output logic                  full_o,
	output router_pkg::fifo_lvl_t level_o
);
	import router_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [0:DEPTH-1];  // packet storage
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW-1:0]    rd_ptr_nxt;         // head slot after this cycle
	fifo_lvl_t        cnt_q;              // occupancy
	logic             do_wr;
	logic             do_rd;

	// pointer step with wrap at DEPTH
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		ptr_inc = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_wr = wr_i & ~full_o;    // write to full fifo dropped
	assign do_rd = rd_i & ~empty_o;   // read of empty fifo dropped
	assign rd_ptr_nxt = do_rd ? ptr_inc(rd_ptr) : rd_ptr;

	assign empty_o = (cnt_q == '0);
	assign full_o  = (cnt_q == fifo_lvl_t'(DEPTH));
	assign level_o = cnt_q;

	always_ff @(posedge clk_i) begin
		if (do_wr)
			mem[wr_ptr] <= wdata_i;
	end

	// head register, bypass when the new word becomes the head
	always_ff @(posedge clk_i) begin
		if (do_wr && (wr_ptr == rd_ptr_nxt))
			rdata_o <= wdata_i;
		else
			rdata_o <= mem[rd_ptr_nxt];
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt_q  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			rd_ptr <= rd_ptr_nxt;
			case ({do_wr, do_rd})
				2'b10:   cnt_q <= cnt_q + 1'b1;  // push only
				2'b01:   cnt_q <= cnt_q - 1'b1;  // pop only
				default: cnt_q <= cnt_q;         // both or neither
			endcase
		end
	end

endmodule

/* router_link_rx.sv */
`timescale 1ns/1ns

module router_link_rx #(
	parameter int DATA_SYMS  = router_pkg::DEF_DATA_SYMS,
	parameter int FIFO_DEPTH = router_pkg::DEF_FIFO_DEPTH
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   clear_i,      // abort frame, clear flags
	input  router_pkg::sym_t       rxd_i,        // async link line
	input  logic                   rd_i,         // pop from merge stage
	output logic [3*DATA_SYMS-1:0] rdata_o,      // head packet
	output logic                   empty_o,
	output logic                   frame_err_o,  // last stop symbol was bad
	output logic                   overrun_o     // sticky, frame lost to full fifo
);
	import router_pkg::*;

	localparam int PKT_W    = 3 * DATA_SYMS;
	localparam int STOP_CNT = OVERSAMPLE * (DATA_SYMS + 1) + 1;  // stop sample point
	localparam int CNT_W    = $clog2(STOP_CNT + 1);

	sym_t             sync_q [0:3];  // line synchronizer
	rx_state_t        state_q;
	logic [CNT_W-1:0] cnt_q;         // clocks since frame start
	logic [PKT_W-1:0] pkt_q;         // packet being assembled
	logic             samp_tick;     // mid symbol
	logic             stop_tick;     // stop symbol sample
	logic             data_tick;     // data symbol sample
	logic             fifo_full;
	logic             fifo_wr;

	// ==============================
	// synchronizer
	// ==============================
	always_ff @(posedge clk_i) begin
		sync_q[0] <= rxd_i;
		for (int i = 1; i < 4; i++)
			sync_q[i] <= sync_q[i-1];  // four flop chain
	end

	// ==============================
	// sample points
	// ==============================
	assign samp_tick = (cnt_q % CNT_W'(OVERSAMPLE)) == CNT_W'(1);
	assign stop_tick = (state_q == RX_FRAME) && (cnt_q == CNT_W'(STOP_CNT));
	assign data_tick = (state_q == RX_FRAME) && samp_tick
		&& (cnt_q > CNT_W'(1)) && (cnt_q < CNT_W'(STOP_CNT));  // skip start, stop

	// write only with room, else overrun below
	assign fifo_wr = stop_tick & ~fifo_full & ~clear_i;

	// counter runs only inside a frame
	always_ff @(posedge clk_i) begin
		if (rst_i || state_q == RX_IDLE)
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// ==============================
	// frame state machine
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= RX_IDLE;
			frame_err_o <= 1'b0;
			overrun_o   <= 1'b0;
		end else if (clear_i) begin
			state_q     <= RX_IDLE;  // drop partial frame
			frame_err_o <= 1'b0;
			overrun_o   <= 1'b0;
		end else begin
			case (state_q)
				RX_IDLE: begin
					if (sync_q[3] == SYM_START)
						state_q <= RX_FRAME;  // first zero seen
				end
				RX_FRAME: begin
					// start must still be low one clock later
					if (cnt_q == CNT_W'(1) && sync_q[3] != SYM_START)
						state_q <= RX_IDLE;
					if (stop_tick) begin
						frame_err_o <= (sync_q[3] != SYM_STOP);
						if (fifo_full)
							overrun_o <= 1'b1;   // frame lost
						state_q <= RX_IDLE;      // idle from next clock
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// shift in from the top, first symbol lands in low bits
	always_ff @(posedge clk_i) begin
		if (data_tick)
			pkt_q <= {sync_q[3], pkt_q[PKT_W-1:3]};
	end

	// ==============================
	// packet fifo
	// ==============================
	router_pkt_fifo #(
		.WIDTH (PKT_W),
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.wr_i    (fifo_wr),
		.wdata_i (pkt_q),
		.rd_i    (rd_i),
		.rdata_o (rdata_o),
		.empty_o (empty_o),
		.full_o  (fifo_full),
		.level_o ()
	);

endmodule

/* router_merge.sv */
`timescale 1ns/1ns

module router_merge #(
	parameter int DATA_SYMS = router_pkg::DEF_DATA_SYMS,
	parameter int CREDITS   = router_pkg::DEF_CREDITS
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   credit_i,     // one credit back from downstream
	input  logic                   empty0_i,
	input  logic [3*DATA_SYMS-1:0] rdata0_i,
	input  logic                   empty1_i,
	input  logic [3*DATA_SYMS-1:0] rdata1_i,
	output logic                   rd0_o,        // pop link 0 fifo
	output logic                   rd1_o,        // pop link 1 fifo
	output logic                   pkt_valid_o,
	output logic [3*DATA_SYMS-1:0] pkt_data_o,
	output router_pkg::link_id_t   pkt_src_o
);
	import router_pkg::*;

	credit_cnt_t credit_q;   // credits in hand
	link_id_t    last_q;     // link served most recently
	link_id_t    sel;        // link chosen this cycle
	logic        any_req;
	logic        pop;

	// ==============================
	// arbitration
	// ==============================
	assign any_req = ~(empty0_i & empty1_i);

	always_comb begin
		if (empty0_i ^ empty1_i)
			sel = link_id_t'(empty0_i);  // only one waiting, take it
		else
			sel = ~last_q;               // both waiting, rotate
	end

	assign pop   = any_req & (credit_q != '0);  // need a credit to send
	assign rd0_o = pop & (sel == 1'b0);
	assign rd1_o = pop & (sel == 1'b1);

	// ==============================
	// credit counter
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			credit_q <= credit_cnt_t'(CREDITS);
			last_q   <= 1'b1;  // link 0 goes first
		end else begin
			case ({pop, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;  // spent one
				2'b01:   credit_q <= credit_q + 1'b1;  // got one back
				default: credit_q <= credit_q;         // net zero
			endcase
			if (pop)
				last_q <= sel;
		end
	end

	// ==============================
	// output register
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i)
			pkt_valid_o <= 1'b0;
		else
			pkt_valid_o <= pop;  // one clock after the pop
	end

	always_ff @(posedge clk_i) begin
		if (pop) begin
			pkt_data_o <= sel ? rdata1_i : rdata0_i;
			pkt_src_o  <= sel;
		end
	end

endmodule

/* router_rx_top.sv */
`timescale 1ns/1ns

module router_rx_top #(
	parameter int DATA_SYMS  = router_pkg::DEF_DATA_SYMS,
	parameter int FIFO_DEPTH = router_pkg::DEF_FIFO_DEPTH,
	parameter int CREDITS    = router_pkg::DEF_CREDITS
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   clear_i,      // to both receivers
	input  router_pkg::sym_t       rxd0_i,       // link 0 line
	input  router_pkg::sym_t       rxd1_i,       // link 1 line
	input  logic                   credit_i,
	output logic                   pkt_valid_o,
	output logic [3*DATA_SYMS-1:0] pkt_data_o,
	output router_pkg::link_id_t   pkt_src_o,
	output logic [1:0]             frame_err_o,  // per link
	output logic [1:0]             overrun_o     // per link
);

	// fifo read side of each link
	logic                   empty0;
	logic                   empty1;
	logic [3*DATA_SYMS-1:0] rdata0;
	logic [3*DATA_SYMS-1:0] rdata1;
	logic                   rd0;
	logic                   rd1;

	// ==============================
	// link receivers
	// ==============================
	router_link_rx #(
		.DATA_SYMS  (DATA_SYMS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_link_rx0 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.clear_i     (clear_i),
		.rxd_i       (rxd0_i),
		.rd_i        (rd0),
		.rdata_o     (rdata0),
		.empty_o     (empty0),
		.frame_err_o (frame_err_o[0]),
		.overrun_o   (overrun_o[0])
	);

	router_link_rx #(
		.DATA_SYMS  (DATA_SYMS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_link_rx1 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.clear_i     (clear_i),
		.rxd_i       (rxd1_i),
		.rd_i        (rd1),
		.rdata_o     (rdata1),
		.empty_o     (empty1),
		.frame_err_o (frame_err_o[1]),
		.overrun_o   (overrun_o[1])
	);

	// ==============================
	// merge under credits
	// ==============================
	router_merge #(
		.DATA_SYMS (DATA_SYMS),
		.CREDITS   (CREDITS)
	) u_merge (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.credit_i    (credit_i),
		.empty0_i    (empty0),
		.rdata0_i    (rdata0),
		.empty1_i    (empty1),
		.rdata1_i    (rdata1),
		.rd0_o       (rd0),
		.rd1_o       (rd1),
		.pkt_valid_o (pkt_valid_o),
		.pkt_data_o  (pkt_data_o),
		.pkt_src_o   (pkt_src_o)
	);

endmodule

/* tb_router_link_drv.svh */
// ==============================
// link line drivers
// ==============================

// hold one symbol on a link for a full symbol time
task automatic hold_sym(input int link, input sym_t s);
	@(negedge clk);
	if (link == 0)
		rxd0 = s;
	else
		rxd1 = s;
	repeat (OVERSAMPLE - 1) @(negedge clk);  // rest of the symbol
endtask

// start, data symbols low bits first, stop, one idle symbol
task automatic send_frame(input int link, input logic [PKT_W-1:0] data, input sym_t stop);
	hold_sym(link, SYM_START);
	for (int k = 0; k < DATA_SYMS; k++)
		hold_sym(link, data[3*k +: 3]);
	hold_sym(link, stop);      // may be a bad stop symbol
	hold_sym(link, SYM_STOP);  // gap before the next frame
endtask

// single clock low pulse on an idle line
task automatic send_glitch(input int link);
	@(negedge clk);
	if (link == 0)
		rxd0 = SYM_START;
	else
		rxd1 = SYM_START;
	@(negedge clk);
	if (link == 0)
		rxd0 = SYM_STOP;  // back to idle
	else
		rxd1 = SYM_STOP;
	repeat (4 * OVERSAMPLE) @(negedge clk);  // let the receiver settle
endtask

// ==============================
// packet data source
// ==============================
logic [31:0] lcg_state = 32'he17d_2be2;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// packet built from the upper lcg bits, 16 at a time
function automatic logic [PKT_W-1:0] rand_pkt();
	logic [PKT_W-1:0] v;
	logic [31:0]      r;
	v = '0;
	for (int i = 0; i < PKT_W; i += 16) begin
		r = lcg_next();
		v = (v << 16) | PKT_W'(r[31:16]);
	end
	return v;
endfunction

/* tb_router_rx.sv */
`timescale 1ns/1ns

module tb_router_rx;
	import router_pkg::*;

	localparam int DATA_SYMS  = DEF_DATA_SYMS;
	localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
	localparam int CREDITS    = DEF_CREDITS;
	localparam int PKT_W      = 3 * DATA_SYMS;
	localparam int SLOT_CYC   = OVERSAMPLE * (DATA_SYMS + 3);  // start, data, stop, gap
	localparam int N_SLOTS    = 10 + 6 + 2 + (CREDITS + FIFO_DEPTH + 1) + 2;
	localparam int MAX_CYC    = 3 * SLOT_CYC * N_SLOTS;

	logic             clk;
	logic             rst;
	logic             clear;
	logic             credit;
	sym_t             rxd0;
	sym_t             rxd1;
	logic             pkt_valid;
	logic [PKT_W-1:0] pkt_data;
	link_id_t         pkt_src;
	logic [1:0]       frame_err;
	logic [1:0]       overrun;

	logic [PKT_W-1:0] exp_q0 [$];  // expected packets, link 0
	logic [PKT_W-1:0] exp_q1 [$];
	int               outstanding;  // received minus credits returned
	int               cycles;
	bit               credit_en;    // downstream returns credits
	bit               alt_en;       // round robin check armed
	bit               have_prev;
	link_id_t         prev_src;

	`include "tb_router_link_drv.svh"

	router_rx_top #(
		.DATA_SYMS  (DATA_SYMS),
		.FIFO_DEPTH (FIFO_DEPTH),
		.CREDITS    (CREDITS)
	) u_router_rx_top (
		.clk_i       (clk),
		.rst_i       (rst),
		.clear_i     (clear),
		.rxd0_i      (rxd0),
		.rxd1_i      (rxd1),
		.credit_i    (credit),
		.pkt_valid_o (pkt_valid),
		.pkt_data_o  (pkt_data),
		.pkt_src_o   (pkt_src),
		.frame_err_o (frame_err),
		.overrun_o   (overrun)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic wait_drained();
		while (exp_q0.size() != 0 || exp_q1.size() != 0)
			@(negedge clk);
	endtask

	// downstream never holds more than the credits handed out
	assert property (@(posedge clk) disable iff (rst) outstanding <= CREDITS)
		else abort_run("more packets received than credits allow");

	// ==============================
	// scoreboard and credit return
	// ==============================
	always @(negedge clk) begin : scoreboard
		logic [PKT_W-1:0] exp;
		credit = 1'b0;
		if (!rst && pkt_valid) begin
			if (pkt_src) begin
				if (exp_q1.size() == 0)
					abort_run("packet on link 1 with none expected");
				exp = exp_q1.pop_front();
			end else begin
				if (exp_q0.size() == 0)
					abort_run("packet on link 0 with none expected");
				exp = exp_q0.pop_front();
			end
			assert (pkt_data === exp)
				else abort_run($sformatf("ERR pkt_data_o got %h exp %h", pkt_data, exp));
			if (alt_en && have_prev)
				assert (pkt_src != prev_src)
					else abort_run($sformatf("ERR pkt_src_o got %h exp %h",
						pkt_src, ~prev_src));
			prev_src = pkt_src;
			have_prev = 1'b1;
			outstanding++;
		end
		if (credit_en && outstanding > 0) begin
			credit = 1'b1;  // one credit per cycle
			outstanding--;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYC)
			abort_run("run did not finish within the cycle limit");
	end

	// ==============================
	// test sequence
	// ==============================
	initial begin
		logic [PKT_W-1:0] d0;
		logic [PKT_W-1:0] d1;
		clk = 1'b0;
		rst = 1'b1;
		clear = 1'b0;
		credit = 1'b0;
		rxd0 = SYM_STOP;  // lines idle high
		rxd1 = SYM_STOP;
		credit_en = 1'b1;
		alt_en = 1'b0;
		have_prev = 1'b0;
		prev_src = 1'b0;
		outstanding = 0;
		cycles = 0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (pkt_valid == 1'b0)
			else abort_run($sformatf("ERR pkt_valid_o got %h exp %h", pkt_valid, 1'b0));
		assert (frame_err == 2'b00)
			else abort_run($sformatf("ERR frame_err_o got %h exp %h", frame_err, 2'b00));
		assert (overrun == 2'b00)
			else abort_run($sformatf("ERR overrun_o got %h exp %h", overrun, 2'b00));

		// random traffic on both links
		for (int i = 0; i < 10; i++) begin
			d0 = rand_pkt();
			d1 = rand_pkt();
			exp_q0.push_back(d0);
			exp_q1.push_back(d1);
			fork
				send_frame(0, d0, SYM_STOP);
				send_frame(1, d1, SYM_STOP);
			join
		end
		wait_drained();

		// credits withheld, then backlog drains round robin
		while (outstanding != 0)
			@(negedge clk);
		credit_en = 1'b0;
		for (int i = 0; i < 6; i++) begin
			d0 = rand_pkt();
			d1 = rand_pkt();
			exp_q0.push_back(d0);
			exp_q1.push_back(d1);
			fork
				send_frame(0, d0, SYM_STOP);
				send_frame(1, d1, SYM_STOP);
			join
		end
		while (outstanding != CREDITS)
			@(negedge clk);
		repeat (SLOT_CYC) begin  // nothing may move now
			@(negedge clk);
			assert (pkt_valid == 1'b0)
				else abort_run($sformatf("ERR pkt_valid_o got %h exp %h", pkt_valid, 1'b0));
		end
		have_prev = 1'b0;
		alt_en = 1'b1;
		credit_en = 1'b1;
		wait_drained();
		alt_en = 1'b0;

		// bad stop symbol still delivers the packet
		d1 = rand_pkt();
		exp_q1.push_back(d1);
		send_frame(1, d1, 3'd3);
		wait_drained();
		assert (frame_err == 2'b10)
			else abort_run($sformatf("ERR frame_err_o got %h exp %h", frame_err, 2'b10));
		d1 = rand_pkt();
		exp_q1.push_back(d1);
		send_frame(1, d1, SYM_STOP);
		wait_drained();
		assert (frame_err == 2'b00)
			else abort_run($sformatf("ERR frame_err_o got %h exp %h", frame_err, 2'b00));

		// spend all credits, fill fifo 0, one more frame overruns
		while (outstanding != 0)
			@(negedge clk);
		credit_en = 1'b0;
		for (int i = 0; i < CREDITS + FIFO_DEPTH + 1; i++) begin
			d0 = rand_pkt();
			if (i < CREDITS + FIFO_DEPTH)
				exp_q0.push_back(d0);  // last one is lost
			send_frame(0, d0, SYM_STOP);
		end
		while (overrun == 2'b00)
			@(negedge clk);
		assert (overrun == 2'b01)
			else abort_run($sformatf("ERR overrun_o got %h exp %h", overrun, 2'b01));
		clear = 1'b1;
		@(negedge clk);
		clear = 1'b0;
		assert (overrun == 2'b00)
			else abort_run($sformatf("ERR overrun_o got %h exp %h", overrun, 2'b00));
		credit_en = 1'b1;
		wait_drained();

		// glitches give no packet, next frames are fine
		send_glitch(0);
		send_glitch(1);
		d0 = rand_pkt();
		d1 = rand_pkt();
		exp_q0.push_back(d0);
		exp_q1.push_back(d1);
		fork
			send_frame(0, d0, SYM_STOP);
			send_frame(1, d1, SYM_STOP);
		join
		wait_drained();
		while (outstanding != 0)
			@(negedge clk);

		if (frame_err == 2'b00 && overrun == 2'b00) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run($sformatf("ERR frame_err_o got %h overrun_o got %h exp %h",
				frame_err, overrun, 2'b00));
		end
	end

endmodule

/* verilog.f */
+incdir+.
router_pkg.sv
router_pkt_fifo.sv
router_link_rx.sv
router_merge.sv
router_rx_top.sv
tb_router_rx.sv
